// File: flist.f
+incdir+verilog
verilog/mm_pkg.sv
verilog/matrix_pack.sv
verilog/mm_sequencer.sv
verilog/dot_product_unit.sv
verilog/result_buffer.sv
verilog/matrix_unpack.sv
verilog/matrix_multiplier.sv
test/mm_sva.sv
test/tb_matrix_multiplier.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_matrix_multiplier
RTL_TOP   ?= matrix_multiplier
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_matrix_multiplier.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module tb_matrix_multiplier;

    localparam int        CLK_PERIOD  = 10;
    localparam int        NUM_RUNS    = 16;
    localparam int        CYCLE_LIMIT = 40 * NUM_RUNS + 100;
    localparam bit [31:0] SEED        = 32'hae96_9d8d;

    logic          clk;
    logic          reset_n;
    logic          en;
    mm_pkg::dim_t  r1;
    mm_pkg::dim_t  c1;
    mm_pkg::dim_t  r2;
    mm_pkg::dim_t  c2;
    mm_pkg::grid_t a_data;
    mm_pkg::grid_t b_data;
    logic          busy;
    logic          is_valid;
    logic          done;
    mm_pkg::dim_t  r_out;
    mm_pkg::dim_t  c_out;
    mm_pkg::grid_t data_out;

    int unsigned   cycle_count = 0;

    matrix_multiplier u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .r1       (r1),
        .c1       (c1),
        .a_data   (a_data),
        .r2       (r2),
        .c2       (c2),
        .b_data   (b_data),
        .busy     (busy),
        .is_valid (is_valid),
        .done     (done),
        .r_out    (r_out),
        .c_out    (c_out),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("timeout: runs not finished after %0d cycles",
                                        CYCLE_LIMIT));
        end
        // bound protocol checks count their own failures
        if (u_dut.u_mm_sva.error_count != 0) begin
            stop_with_failure("a protocol assertion bound to the DUT has failed");
        end
    end

    task automatic expect_equal(input string what, input logic [255:0] got,
                                input logic [255:0] exp);
        assert (got === exp)
        else stop_with_failure($sformatf("ERR %0t: %s is %0h, expected %0h",
                                         $time, what, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic mm_pkg::grid_t random_grid();
        mm_pkg::grid_t g;
        for (int i = 0; i < `MM_SLOTS; i++) begin
            g[i] = mm_pkg::elem_t'($urandom);
        end
        return g;
    endfunction

    // dense row-major product, every sum wraps at the element width
    function automatic mm_pkg::grid_t reference_product(input int ar, input int ac,
        input int bc, input mm_pkg::grid_t a, input mm_pkg::grid_t b);
        mm_pkg::grid_t prod;
        int            acc;
        prod = '0;
        for (int i = 0; i < ar; i++) begin
            for (int j = 0; j < bc; j++) begin
                acc = 0;
                for (int k = 0; k < ac; k++) begin
                    acc = acc + int'(a[i * ac + k]) * int'(b[k * bc + j]);
                end
                prod[i * bc + j] = mm_pkg::elem_t'(acc % (1 << `MM_DATA_WIDTH));
            end
        end
        return prod;
    endfunction

    task automatic start_run(input int ar, input int ac, input int br, input int bc);
        r1     = mm_pkg::dim_t'(ar);
        c1     = mm_pkg::dim_t'(ac);
        r2     = mm_pkg::dim_t'(br);
        c2     = mm_pkg::dim_t'(bc);
        a_data = random_grid();
        b_data = random_grid();
        en     = 1'b1;
        next_cycle();
        expect_equal("busy after start", busy, 1'b1);
    endtask

    // status clears on the edge that sees en low, data one edge later
    task automatic end_run();
        en = 1'b0;
        next_cycle();
        expect_equal("busy after en low", busy, 1'b0);
        expect_equal("done after en low", done, 1'b0);
        expect_equal("is_valid after en low", is_valid, 1'b1);
        expect_equal("r_out after en low", r_out, '0);
        expect_equal("c_out after en low", c_out, '0);
        next_cycle();
        expect_equal("data_out after clear", data_out, '0);
    endtask

    task automatic run_product(input int ar, input int ac, input int bc);
        mm_pkg::grid_t expected;
        string         shape;
        shape = $sformatf("%0dx%0d*%0dx%0d", ar, ac, ac, bc);
        start_run(ar, ac, ac, bc);
        expected = reference_product(ar, ac, bc, a_data, b_data);
        while (!done) begin
            next_cycle();
        end
        expect_equal({"data_out of ", shape}, data_out, expected);
        expect_equal({"r_out of ", shape}, r_out, mm_pkg::dim_t'(ar));
        expect_equal({"c_out of ", shape}, c_out, mm_pkg::dim_t'(bc));
        expect_equal({"busy at done of ", shape}, busy, 1'b0);
        repeat (2) next_cycle();
        expect_equal({"held data_out of ", shape}, data_out, expected);
        end_run();
    endtask

    task automatic run_mismatch(input int ar, input int ac, input int br, input int bc);
        start_run(ar, ac, br, bc);
        while (is_valid) begin
            next_cycle();
        end
        expect_equal("busy on mismatch", busy, 1'b0);
        expect_equal("done on mismatch", done, 1'b0);
        expect_equal("data_out on mismatch", data_out, '0);
        repeat (3) next_cycle();
        expect_equal("is_valid while mismatch held", is_valid, 1'b0);
        end_run();
    endtask

    initial begin
        void'($urandom(SEED));
        reset_n = 1'b0;
        en      = 1'b0;
        r1      = 3'd1;
        c1      = 3'd1;
        r2      = 3'd1;
        c2      = 3'd1;
        a_data  = '0;
        b_data  = '0;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
        next_cycle();
        expect_equal("busy after reset", busy, 1'b0);
        expect_equal("done after reset", done, 1'b0);
        expect_equal("is_valid after reset", is_valid, 1'b1);
        expect_equal("data_out after reset", data_out, '0);
        expect_equal("r_out after reset", r_out, '0);
        expect_equal("c_out after reset", c_out, '0);

        // full-range elements wrap often
        repeat (6) run_product(5, 5, 5);
        run_product(2, 3, 4);
        run_product(1, 5, 1);
        run_product(4, 1, 4);
        run_product(3, 5, 2);
        for (int n = 0; n < 4; n++) begin
            run_product(int'($urandom_range(5, 1)), int'($urandom_range(5, 1)),
                        int'($urandom_range(5, 1)));
        end
        run_mismatch(2, 3, 4, 2);
        run_mismatch(5, 1, 3, 5);

        if (u_dut.u_mm_sva.error_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("a protocol assertion bound to the DUT has failed");
        end
    end

endmodule

// File: test/mm_sva.sv
`timescale 1ns/10ps

module mm_sva (
    input logic          clk,
    input logic          reset_n,
    input logic          en,
    input mm_pkg::dim_t  r1,
    input mm_pkg::dim_t  c1,
    input mm_pkg::dim_t  r2,
    input mm_pkg::dim_t  c2,
    input mm_pkg::grid_t a_data,
    input mm_pkg::grid_t b_data,
    input logic          busy,
    input logic          is_valid,
    input logic          done,
    input mm_pkg::dim_t  r_out,
    input mm_pkg::dim_t  c_out,
    input mm_pkg::grid_t data_out
);

    int unsigned error_count = 0;

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(busy && done))
        else begin
            $error("busy and done are high in the same cycle");
            error_count++;
        end

    // matched run finishes 28 cycles after the start
    a_done_latency: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(en) && (c1 == r2) |-> ##[1:32] done)
        else begin
            $error("done did not arrive within 32 cycles of en");
            error_count++;
        end

    a_done_holds: assert property (@(posedge clk) disable iff (!reset_n)
        done && en |=> done)
        else begin
            $error("done dropped while en stayed high");
            error_count++;
        end

    a_operands_stable: assert property (@(posedge clk) disable iff (!reset_n)
        en && $past(en) |-> $stable(r1) && $stable(c1) && $stable(r2) && $stable(c2)
                            && $stable(a_data) && $stable(b_data))
        else begin
            $error("operand inputs changed while en was high");
            error_count++;
        end

    a_dims_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        en |-> (r1 inside {[1:5]}) && (c1 inside {[1:5]})
               && (r2 inside {[1:5]}) && (c2 inside {[1:5]}))
        else begin
            $error("row or column count outside 1..5 while en is high");
            error_count++;
        end

    a_mismatch_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        !is_valid |-> !done && (data_out == '0))
        else begin
            $error("done or data_out set during a dimension mismatch");
            error_count++;
        end

    a_clear_status: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(en) |=> !busy && !done && is_valid && (r_out == '0) && (c_out == '0))
        else begin
            $error("status outputs not cleared after en fell");
            error_count++;
        end

    a_clear_data: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(en) |-> ##2 (data_out == '0))
        else begin
            $error("data_out not cleared after en fell");
            error_count++;
        end

endmodule

bind matrix_multiplier mm_sva u_mm_sva (.*);

// File: verilog/matrix_multiplier.sv
`timescale 1ns/10ps

module matrix_multiplier (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          en,
    input  mm_pkg::dim_t  r1,
    input  mm_pkg::dim_t  c1,
    input  mm_pkg::grid_t a_data,
    input  mm_pkg::dim_t  r2,
    input  mm_pkg::dim_t  c2,
    input  mm_pkg::grid_t b_data,
    output logic          busy,
    output logic          is_valid,
    output logic          done,
    output mm_pkg::dim_t  r_out,
    output mm_pkg::dim_t  c_out,
    output mm_pkg::grid_t data_out
);

    logic          load;
    logic          wr_en;
    logic          store;
    logic          clear;
    mm_pkg::dim_t  row_idx;
    mm_pkg::dim_t  col_idx;
    mm_pkg::idx_t  wr_idx;
    mm_pkg::elem_t sum;
    mm_pkg::grid_t a_grid;
    mm_pkg::grid_t b_grid;
    mm_pkg::grid_t result_grid;

    matrix_pack u_pack_a (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (load),
        .r       (r1),
        .c       (c1),
        .data_in (a_data),
        .grid    (a_grid)
    );

    matrix_pack u_pack_b (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (load),
        .r       (r2),
        .c       (c2),
        .data_in (b_data),
        .grid    (b_grid)
    );

    mm_sequencer u_sequencer (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .r1       (r1),
        .c1       (c1),
        .r2       (r2),
        .c2       (c2),
        .load     (load),
        .row_idx  (row_idx),
        .col_idx  (col_idx),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .store    (store),
        .clear    (clear),
        .r_out    (r_out),
        .c_out    (c_out),
        .busy     (busy),
        .is_valid (is_valid),
        .done     (done)
    );

    dot_product_unit u_dot (
        .a_grid  (a_grid),
        .b_grid  (b_grid),
        .row_idx (row_idx),
        .col_idx (col_idx),
        .sum     (sum)
    );

    result_buffer u_buffer (
        .clk     (clk),
        .reset_n (reset_n),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (sum),
        .clear   (clear),
        .grid    (result_grid)
    );

    // result shape comes from the latched r_out and c_out
    matrix_unpack u_unpack (
        .clk      (clk),
        .reset_n  (reset_n),
        .store    (store),
        .clear    (clear),
        .r        (r_out),
        .c        (c_out),
        .grid     (result_grid),
        .data_out (data_out)
    );

endmodule

// File: verilog/matrix_unpack.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module matrix_unpack (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          store,
    input  logic          clear,
    input  mm_pkg::dim_t  r,
    input  mm_pkg::dim_t  c,
    input  mm_pkg::grid_t grid,
    output mm_pkg::grid_t data_out
);

    mm_pkg::grid_t dense;

    // grid row*5+col back to dense row*c+col, tail left at zero
    always_comb begin
        dense = '0;
        for (int row = 0; row < `MM_GRID_DIM; row++) begin
            for (int col = 0; col < `MM_GRID_DIM; col++) begin
                if (row < int'(r) && col < int'(c)) begin
                    dense[row * int'(c) + col] = grid[row * `MM_GRID_DIM + col];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out <= '0;
        end else if (clear) begin
            data_out <= '0;
        end else if (store) begin
            data_out <= dense;
        end
    end

endmodule

// File: verilog/result_buffer.sv
`timescale 1ns/10ps

module result_buffer (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          wr_en,
    input  mm_pkg::idx_t  wr_idx,
    input  mm_pkg::elem_t wr_data,
    input  logic          clear,
    output mm_pkg::grid_t grid
);

    // one dot product lands per cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid <= '0;
        end else if (clear) begin
            grid <= '0;
        end else if (wr_en) begin
            grid[wr_idx] <= wr_data;
        end
    end

endmodule

// File: verilog/dot_product_unit.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module dot_product_unit (
    input  mm_pkg::grid_t a_grid,
    input  mm_pkg::grid_t b_grid,
    input  mm_pkg::dim_t  row_idx,
    input  mm_pkg::dim_t  col_idx,
    output mm_pkg::elem_t sum
);

    mm_pkg::elem_t a_row [`MM_GRID_DIM];
    mm_pkg::elem_t b_col [`MM_GRID_DIM];
    mm_pkg::elem_t prod  [`MM_GRID_DIM];

    // one row of A against one column of B
    always_comb begin
        for (int i = 0; i < `MM_GRID_DIM; i++) begin
            a_row[i] = a_grid[int'(row_idx) * `MM_GRID_DIM + i];
            b_col[i] = b_grid[i * `MM_GRID_DIM + int'(col_idx)];
            // product keeps only the low bits
            prod[i]  = a_row[i] * b_col[i];
        end
    end

    // padded slots add zero terms
    always_comb begin
        sum = '0;
        for (int i = 0; i < `MM_GRID_DIM; i++) begin
            sum = sum + prod[i];
        end
    end

endmodule

// File: verilog/mm_sequencer.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module mm_sequencer (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         en,
    input  mm_pkg::dim_t r1,
    input  mm_pkg::dim_t c1,
    input  mm_pkg::dim_t r2,
    input  mm_pkg::dim_t c2,
    output logic         load,
    output mm_pkg::dim_t row_idx,
    output mm_pkg::dim_t col_idx,
    output logic         wr_en,
    output mm_pkg::idx_t wr_idx,
    output logic         store,
    output logic         clear,
    output mm_pkg::dim_t r_out,
    output mm_pkg::dim_t c_out,
    output logic         busy,
    output logic         is_valid,
    output logic         done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_CHECK,
        ST_COMPUTE,
        ST_FINISH,
        ST_HOLD,
        ST_MISMATCH
    } state_t;

    localparam mm_pkg::idx_t LAST_IDX = mm_pkg::idx_t'(`MM_SLOTS - 1);

    state_t       state;
    mm_pkg::idx_t cnt;

    assign load    = (state == ST_LOAD);
    assign wr_en   = (state == ST_COMPUTE);
    assign store   = (state == ST_FINISH);
    assign wr_idx  = cnt;
    // k gives row k/5 and column k%5
    assign row_idx = mm_pkg::dim_t'(cnt / `MM_GRID_DIM);
    assign col_idx = mm_pkg::dim_t'(cnt % `MM_GRID_DIM);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            clear    <= 1'b0;
            r_out    <= '0;
            c_out    <= '0;
            busy     <= 1'b0;
            is_valid <= 1'b1;
            done     <= 1'b0;
        end else begin
            clear <= 1'b0;
            if (!en) begin
                // en low aborts or ends any run
                clear    <= (state != ST_IDLE);
                state    <= ST_IDLE;
                cnt      <= '0;
                r_out    <= '0;
                c_out    <= '0;
                busy     <= 1'b0;
                is_valid <= 1'b1;
                done     <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        busy  <= 1'b1;
                        state <= ST_LOAD;
                    end
                    ST_LOAD: state <= ST_CHECK;
                    ST_CHECK: begin
                        if (c1 == r2) begin
                            r_out <= r1;
                            c_out <= c2;
                            cnt   <= '0;
                            state <= ST_COMPUTE;
                        end else begin
                            busy     <= 1'b0;
                            is_valid <= 1'b0;
                            state    <= ST_MISMATCH;
                        end
                    end
                    ST_COMPUTE: begin
                        if (cnt == LAST_IDX) begin
                            cnt   <= '0;
                            state <= ST_FINISH;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    ST_FINISH: begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= ST_HOLD;
                    end
                    // hold and mismatch wait here for en to fall
                    default: state <= state;
                endcase
            end
        end
    end

endmodule

// File: verilog/matrix_pack.sv
`timescale 1ns/10ps
`include "mm_cfg.svh"

module matrix_pack (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          load,
    input  mm_pkg::dim_t  r,
    input  mm_pkg::dim_t  c,
    input  mm_pkg::grid_t data_in,
    output mm_pkg::grid_t grid
);

    mm_pkg::grid_t grid_next;

    // dense row*c+col moves to grid row*5+col
    always_comb begin
        grid_next = '0;
        for (int row = 0; row < `MM_GRID_DIM; row++) begin
            for (int col = 0; col < `MM_GRID_DIM; col++) begin
                if (row < int'(r) && col < int'(c)) begin
                    grid_next[row * `MM_GRID_DIM + col] = data_in[row * int'(c) + col];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid <= '0;
        end else if (load) begin
            grid <= grid_next;
        end
    end

endmodule

// File: verilog/mm_pkg.sv
`include "mm_cfg.svh"

package mm_pkg;

    // one matrix element
    typedef logic [`MM_DATA_WIDTH-1:0] elem_t;

    // row or column count
    typedef logic [`MM_DIM_WIDTH-1:0] dim_t;

    // slot index 0..24
    typedef logic [$clog2(`MM_SLOTS)-1:0] idx_t;

    // slot 0 in the low bits
    typedef logic [`MM_SLOTS-1:0][`MM_DATA_WIDTH-1:0] grid_t;

endpackage

// File: verilog/mm_cfg.svh
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// element width, all arithmetic wraps at this size
`define MM_DATA_WIDTH 9

// side length of the square working grid
`define MM_GRID_DIM 5

// slots in one grid
`define MM_SLOTS 25

// holds a row or column count of 1..5
`define MM_DIM_WIDTH 3

`endif
